//--- cd_bus_pkg.sv
// CD system controller host bus definitions
// 68000 bus, transfer area mapping, upload strobes and register address map
package cd_bus_pkg;

	typedef struct packed {
		logic [23:1] addr;	// Word address
		logic [15:0] data;
		logic rw;
		logic nas;
		logic nlds;
		logic nuds;
	} cpu_bus_t;

	typedef enum logic [2:0] {
		area_spr = 3'd0,
		area_pcm = 3'd1,
		area_z80 = 3'd4,
		area_fix = 3'd5
	} tr_area_e;

	typedef struct packed {
		logic [2:0] area;
		logic use_spr;
		logic use_pcm;
		logic use_z80;
		logic use_fix;
	} tr_map_t;

	typedef struct packed {
		logic wr_spr;
		logic wr_pcm;
		logic wr_z80;
		logic wr_fix;
		logic rd_spr;
		logic rd_pcm;
		logic rd_z80;
		logic rd_fix;
	} tr_strobe_t;

	// ========================================
	// Address map
	// ========================================
	localparam logic [11:0] reg_page = 12'hFF0;	// addr[23:12]
	localparam logic [3:0] upload_zone = 4'hE;	// addr[23:20]

	// Word offsets, addr[11:1]
	localparam logic [10:0] reg_dma_ctrl = 11'h030;	// FF0061
	localparam logic [10:0] reg_dma_addr_a_h = 11'h032;
	localparam logic [10:0] reg_dma_addr_a_l = 11'h033;
	localparam logic [10:0] reg_dma_addr_b_h = 11'h034;
	localparam logic [10:0] reg_dma_addr_b_l = 11'h035;
	localparam logic [10:0] reg_dma_value = 11'h036;	// FF006C
	localparam logic [10:0] reg_dma_count_h = 11'h038;
	localparam logic [10:0] reg_dma_count_l = 11'h039;
	localparam logic [10:0] reg_dma_microcode = 11'h03F;	// FF007E
	localparam logic [10:0] reg_tr_area = 11'h082;	// FF0105
	localparam logic [10:0] reg_map_spr = 11'h090;
	localparam logic [10:0] reg_map_pcm = 11'h091;
	localparam logic [10:0] reg_map_z80 = 11'h093;
	localparam logic [10:0] reg_map_fix = 11'h094;
	localparam logic [10:0] reg_unmap_spr = 11'h0A0;
	localparam logic [10:0] reg_unmap_pcm = 11'h0A1;
	localparam logic [10:0] reg_unmap_z80 = 11'h0A3;
	localparam logic [10:0] reg_unmap_fix = 11'h0A4;
	localparam logic [10:0] reg_bank_spr = 11'h0D0;	// FF01A1
	localparam logic [10:0] reg_bank_pcm = 11'h0D1;	// FF01A3

	localparam int sector_bytes = 2048;

endpackage

//--- cd_dma_pkg.sv
// CD system controller DMA definitions
// Transfer modes, engine states, microcode words and DMA structures
package cd_dma_pkg;

	typedef enum logic [1:0] {
		dma_copy_cd_word,	// Sector cache to memory
		dma_copy_word,	// Memory to memory
		dma_fill
	} dma_mode_e;

	typedef enum logic [3:0] {
		idle, br, wait_bg, wait_as, start,
		cache_rd_h, cache_rd_l,
		rd, rd_wait, rd_done,
		wr, wr_done, step
	} dma_state_e;

	// First microcode word seen from the BIOS for each mode
	localparam logic [15:0] mc_cd_a = 16'hFF89;
	localparam logic [15:0] mc_cd_b = 16'hFFC5;
	localparam logic [15:0] mc_copy_a = 16'hFE6D;
	localparam logic [15:0] mc_copy_b = 16'hFE3D;
	localparam logic [15:0] mc_fill_a = 16'hFFCD;
	localparam logic [15:0] mc_fill_b = 16'hFFDD;

	typedef struct packed {
		logic [23:0] addr_a;
		logic [23:0] addr_b;
		logic [15:0] value;	// Fill word
		logic [31:0] count;	// In words
		dma_mode_e mode;
	} dma_setup_t;

	typedef struct packed {
		logic rd;
		logic wr;
		logic [23:0] addr_in;	// Read side
		logic [23:0] addr_out;	// Write side
		logic [15:0] data_out;
	} dma_mem_t;

endpackage

//--- cd_host_regs.sv
// CD host register file
// 68000 register writes, DMA setup and start, transfer mapping, upload latch
`timescale 1ns/1ps

module cd_host_regs (
	input logic clk_sys,
	input logic nRESET,
	input logic cpu_clk_en,
	input cd_bus_pkg::cpu_bus_t cpu,
	output cd_dma_pkg::dma_setup_t dma_setup,
	output logic dma_start,
	output cd_bus_pkg::tr_map_t tr_map,
	output logic [1:0] bank_spr,
	output logic bank_pcm,
	output logic [15:0] tr_wr_data,
	output logic [19:1] tr_wr_addr
);
	import cd_bus_pkg::*;
	import cd_dma_pkg::*;

	logic nlds_prev, nuds_prev;
	logic strobe_fall;
	logic word_wr, lo_wr;
	logic [15:0] microcode;
	logic mc_known;
	dma_mode_e mc_mode;

	assign strobe_fall = (nlds_prev & ~cpu.nlds) | (nuds_prev & ~cpu.nuds);
	assign word_wr = ~cpu.nuds & ~cpu.nlds;
	assign lo_wr = ~cpu.nlds;	// Odd byte lane

	// Only microcode word 0 selects the mode
	always_comb
	begin
		mc_known = 1'b1;
		mc_mode = dma_copy_cd_word;
		case (microcode)
			mc_cd_a, mc_cd_b: mc_mode = dma_copy_cd_word;
			mc_copy_a, mc_copy_b: mc_mode = dma_copy_word;
			mc_fill_a, mc_fill_b: mc_mode = dma_fill;
			default: mc_known = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			nlds_prev <= 1'b1;
			nuds_prev <= 1'b1;
			dma_start <= 1'b0;
			tr_map <= '0;
			bank_spr <= 2'd0;
			bank_pcm <= 1'b0;
		end
		else if (cpu_clk_en)
		begin
			nlds_prev <= cpu.nlds;
			nuds_prev <= cpu.nuds;
			dma_start <= 1'b0;	// One period only

			if (strobe_fall && !cpu.rw && cpu.addr[23:12] == reg_page)
			begin
				case (cpu.addr[11:1])
					reg_dma_ctrl:
					if (cpu.nuds && lo_wr && cpu.data[6] && mc_known)
					begin
						dma_start <= 1'b1;
						dma_setup.mode <= mc_mode;
					end
					reg_dma_addr_a_h: if (word_wr) dma_setup.addr_a[23:16] <= cpu.data[7:0];
					reg_dma_addr_a_l: if (word_wr) dma_setup.addr_a[15:0] <= cpu.data;
					reg_dma_addr_b_h: if (word_wr) dma_setup.addr_b[23:16] <= cpu.data[7:0];
					reg_dma_addr_b_l: if (word_wr) dma_setup.addr_b[15:0] <= cpu.data;
					reg_dma_value: if (word_wr) dma_setup.value <= cpu.data;
					reg_dma_count_h: if (word_wr) dma_setup.count[31:16] <= cpu.data;
					reg_dma_count_l: if (word_wr) dma_setup.count[15:0] <= cpu.data;
					reg_dma_microcode: if (word_wr) microcode <= cpu.data;
					reg_tr_area: if (lo_wr) tr_map.area <= cpu.data[2:0];
					reg_map_spr: if (lo_wr) tr_map.use_spr <= 1'b1;
					reg_map_pcm: if (lo_wr) tr_map.use_pcm <= 1'b1;
					reg_map_z80: if (lo_wr) tr_map.use_z80 <= 1'b1;
					reg_map_fix: if (lo_wr) tr_map.use_fix <= 1'b1;
					reg_unmap_spr: if (lo_wr) tr_map.use_spr <= 1'b0;
					reg_unmap_pcm: if (lo_wr) tr_map.use_pcm <= 1'b0;
					reg_unmap_z80: if (lo_wr) tr_map.use_z80 <= 1'b0;
					reg_unmap_fix: if (lo_wr) tr_map.use_fix <= 1'b0;
					reg_bank_spr: if (lo_wr) bank_spr <= cpu.data[1:0];
					reg_bank_pcm: if (lo_wr) bank_pcm <= cpu.data[0];
					default: ;
				endcase
			end
			else if (strobe_fall && !cpu.rw && cpu.addr[23:20] == upload_zone)
			begin
				// Upload zone write, forwarded as is
				tr_wr_data <= cpu.data;
				tr_wr_addr <= cpu.addr[19:1];
			end
		end
	end

	// The engine relies on a single pulse per start write
	a_start_pulse: assert property (@(posedge clk_sys) disable iff (!nRESET)
		cpu_clk_en && dma_start |=> !dma_start);

endmodule

//--- cd_sector_cache.sv
// CD sector cache
// Loads downloaded sectors into two byte banks and swaps the read bank at sector rate
`timescale 1ns/1ps

module cd_sector_cache #(
	parameter int clk_hz = 96671316
) (
	input logic clk_sys,
	input logic nRESET,
	input logic dl_active,
	input logic dl_wr,
	input logic [10:0] dl_addr,
	input logic [15:0] dl_data,
	input logic [1:0] cd_speed,
	input logic [10:0] cache_rd_addr,
	output logic [7:0] cache_dout,
	output logic dl_ready
);
	import cd_bus_pkg::*;

	typedef enum logic [2:0] {ld_idle, ld_hdr, ld_lo, ld_hi, ld_done} load_state_e;

	localparam int unsigned t_1x = clk_hz / 75;
	localparam int unsigned t_2x = clk_hz / 150;
	localparam int unsigned t_3x = clk_hz / 225;
	localparam int unsigned t_4x = clk_hz / 300;

	load_state_e state;
	logic [7:0] mem [0:2*sector_bytes-1];
	logic [1:0] filled;
	logic rd_bank, wr_bank;
	logic [10:0] wr_addr;
	logic [7:0] hi_byte;
	logic dl_wr_prev, wr_end;
	logic mem_we;
	logic [7:0] mem_din;
	logic [23:0] timer, sector_time, time_sel;

	assign wr_end = dl_wr_prev & ~dl_wr;
	assign dl_ready = ~filled[~rd_bank];
	assign mem_we = (state == ld_lo && wr_end && dl_active) || state == ld_hi;
	assign mem_din = (state == ld_hi) ? hi_byte : dl_data[7:0];

	always_comb
	begin
		case (cd_speed)
			2'd0: time_sel = 24'(t_1x);
			2'd1: time_sel = 24'(t_2x);
			2'd2: time_sel = 24'(t_3x);
			default: time_sel = 24'(t_4x);
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (mem_we)
			mem[{wr_bank, wr_addr}] <= mem_din;
		cache_dout <= mem[{rd_bank, cache_rd_addr}];
	end

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state <= ld_idle;
			filled <= 2'b00;
			rd_bank <= 1'b0;
			wr_bank <= 1'b0;
			dl_wr_prev <= 1'b0;
			timer <= '0;
			sector_time <= 24'(t_1x);
		end
		else
		begin
			dl_wr_prev <= dl_wr;

			// ========================================
			// Sector timer and bank swap
			// ========================================
			if (timer < sector_time - 24'd1)
				timer <= timer + 1'b1;
			else if (filled[~rd_bank])
			begin
				filled[rd_bank] <= 1'b0;
				rd_bank <= ~rd_bank;
				timer <= '0;
				sector_time <= time_sel;	// Speed change takes effect here
			end

			case (state)
				ld_idle:
				if (dl_ready && dl_active && wr_end && dl_addr == 11'd6)
				begin
					wr_bank <= ~rd_bank;
					state <= ld_hdr;
				end
				ld_hdr:
				if (!dl_active)
					state <= ld_done;
				else if (wr_end && dl_addr == 11'd7)
				begin
					wr_addr <= '0;
					state <= ld_lo;	// Data words follow
				end
				ld_lo:
				if (!dl_active)
					state <= ld_done;	// Short sector
				else if (wr_end)
				begin
					hi_byte <= dl_data[15:8];
					wr_addr <= wr_addr + 1'b1;
					state <= ld_hi;
				end
				ld_hi:
				begin
					wr_addr <= wr_addr + 1'b1;
					state <= (wr_addr == 11'(sector_bytes - 1)) ? ld_done : ld_lo;
				end
				default:
				begin
					filled[wr_bank] <= 1'b1;
					state <= ld_idle;
				end
			endcase
		end
	end

	// Loading must never overwrite the bank being read out
	a_no_rd_bank_wr: assert property (@(posedge clk_sys) disable iff (!nRESET)
		mem_we |-> wr_bank != rd_bank);

endmodule

//--- cd_dma_engine.sv
// CD DMA engine
// Takes over the 68000 bus and runs cache copy, word copy and fill transfers
`timescale 1ns/1ps

module cd_dma_engine (
	input logic clk_sys,
	input logic nRESET,
	input logic cpu_clk_en,
	input cd_dma_pkg::dma_setup_t dma_setup,
	input logic dma_start,
	input logic nbg,
	input logic nas,
	input logic dtack_n,
	input logic sdram_busy,
	input logic [15:0] dma_data_in,
	input logic [7:0] cache_dout,
	output cd_dma_pkg::dma_mem_t dma_mem,
	output logic dma_running,
	output logic nbr,
	output logic nbgack,
	output logic [10:0] cache_rd_addr
);
	import cd_dma_pkg::*;

	dma_state_e state;
	dma_mode_e mode_q;
	logic start_prev;
	logic have_data;	// Read half of a word done
	logic [31:0] count_run;
	logic [15:0] rd_data;
	logic mem_rd, mem_wr;
	logic [23:0] addr_in, addr_out;
	logic [15:0] data_out;

	assign dma_mem = '{rd: mem_rd, wr: mem_wr, addr_in: addr_in,
		addr_out: addr_out, data_out: data_out};

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state <= idle;
			start_prev <= 1'b0;
			nbr <= 1'b1;
			nbgack <= 1'b1;
			dma_running <= 1'b0;
			mem_rd <= 1'b0;
			mem_wr <= 1'b0;
		end
		else
		begin
			start_prev <= dma_start;

			if (dma_start && !start_prev && state == idle)
			begin
				state <= br;
				mode_q <= dma_setup.mode;
				count_run <= dma_setup.count;
				have_data <= 1'b0;
				cache_rd_addr <= '0;
				addr_in <= dma_setup.addr_a;
				addr_out <= (dma_setup.mode == dma_copy_word) ? dma_setup.addr_b : dma_setup.addr_a;
				data_out <= dma_setup.value;
			end
			else if (cpu_clk_en)
			begin
				case (state)
					br:
					begin
						nbr <= 1'b0;
						state <= wait_bg;
					end
					wait_bg: if (!nbg) state <= wait_as;
					wait_as:
					if (nas && dtack_n)	// Last CPU cycle finished
					begin
						nbr <= 1'b1;
						nbgack <= 1'b0;
						dma_running <= 1'b1;
						state <= start;
					end
					start:
					if (count_run == '0)
					begin
						nbgack <= 1'b1;
						dma_running <= 1'b0;
						state <= idle;
					end
					else
					begin
						case (mode_q)
							dma_copy_cd_word, dma_copy_word:
							if (have_data)
							begin
								data_out <= rd_data;
								state <= wr;
							end
							else
								state <= (mode_q == dma_copy_word) ? rd : cache_rd_h;
							dma_fill: state <= wr;
							default: state <= step;
						endcase
					end
					cache_rd_h:
					begin
						rd_data[15:8] <= cache_dout;	// Even byte first
						cache_rd_addr <= cache_rd_addr + 1'b1;
						state <= cache_rd_l;
					end
					cache_rd_l:
					begin
						rd_data[7:0] <= cache_dout;
						cache_rd_addr <= cache_rd_addr + 1'b1;
						have_data <= 1'b1;
						state <= start;
					end
					rd:
					begin
						mem_rd <= 1'b1;
						state <= rd_wait;
					end
					rd_wait: if (!sdram_busy) state <= rd_done;
					rd_done:
					begin
						mem_rd <= 1'b0;
						rd_data <= dma_data_in;
						addr_in <= addr_in + 24'd2;
						have_data <= 1'b1;
						state <= start;
					end
					wr:
					begin
						mem_wr <= 1'b1;
						state <= wr_done;
					end
					wr_done:
					if (!sdram_busy)
					begin
						mem_wr <= 1'b0;
						addr_out <= addr_out + 24'd2;
						state <= step;
					end
					step:
					begin
						count_run <= count_run - 1'b1;
						have_data <= 1'b0;
						state <= start;
					end
					default: ;
				endcase
			end
		end
	end

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (!nRESET)
		!(mem_rd && mem_wr));

endmodule

//--- cd_transfer_decode.sv
// Upload zone decoder, per-area read and write strobes for CPU or DMA accesses
`timescale 1ns/1ps

module cd_transfer_decode (
	input cd_bus_pkg::cpu_bus_t cpu,
	input cd_bus_pkg::tr_map_t tr_map,
	input cd_dma_pkg::dma_mem_t dma_mem,
	input logic dma_running,
	output cd_bus_pkg::tr_strobe_t tr_strobe
);
	import cd_bus_pkg::*;

	logic [23:0] addr;
	logic acc_rd, acc_wr, zone;
	logic sel_spr, sel_pcm, sel_z80, sel_fix;

	// DMA owns the bus while running
	always_comb
	begin
		if (dma_running)
		begin
			addr = dma_mem.rd ? dma_mem.addr_in : dma_mem.addr_out;
			acc_rd = dma_mem.rd;
			acc_wr = dma_mem.wr;
		end
		else
		begin
			addr = {cpu.addr, 1'b0};
			acc_rd = cpu.rw & ~(cpu.nlds & cpu.nuds);
			acc_wr = ~cpu.rw & ~(cpu.nlds & cpu.nuds);
		end
	end

	assign zone = (addr[23:20] == upload_zone);
	assign sel_spr = zone & (tr_map.area == area_spr) & tr_map.use_spr;
	assign sel_pcm = zone & (tr_map.area == area_pcm) & tr_map.use_pcm;
	assign sel_z80 = zone & (tr_map.area == area_z80) & tr_map.use_z80;
	assign sel_fix = zone & (tr_map.area == area_fix) & tr_map.use_fix;

	assign tr_strobe = '{wr_spr: acc_wr & sel_spr, wr_pcm: acc_wr & sel_pcm,
		wr_z80: acc_wr & sel_z80, wr_fix: acc_wr & sel_fix,
		rd_spr: acc_rd & sel_spr, rd_pcm: acc_rd & sel_pcm,
		rd_z80: acc_rd & sel_z80, rd_fix: acc_rd & sel_fix};

endmodule

//--- cd_sys.sv
// CD system controller top level, host side
// Register file, sector cache, DMA engine and transfer decoder
`timescale 1ns/1ps

module cd_sys #(
	parameter int clk_hz = 96671316
) (
	input logic clk_sys,
	input logic nRESET,
	input logic cpu_clk_en,
	input cd_bus_pkg::cpu_bus_t cpu,
	input logic dl_active,
	input logic dl_wr,
	input logic [10:0] dl_addr,
	input logic [15:0] dl_data,
	input logic [1:0] cd_speed,
	input logic nbg,
	input logic nas,
	input logic dtack_n,
	input logic sdram_busy,
	input logic [15:0] dma_data_in,
	output logic dl_ready,
	output logic [1:0] bank_spr,
	output logic bank_pcm,
	output logic [15:0] tr_wr_data,
	output logic [19:1] tr_wr_addr,
	output cd_bus_pkg::tr_strobe_t tr_strobe,
	output cd_dma_pkg::dma_mem_t dma_mem,
	output logic dma_running,
	output logic nbr,
	output logic nbgack
);
	import cd_bus_pkg::*;
	import cd_dma_pkg::*;

	dma_setup_t dma_setup;
	tr_map_t tr_map;
	logic dma_start;
	logic [10:0] cache_rd_addr;
	logic [7:0] cache_dout;

	cd_host_regs host_regs_inst (.clk_sys, .nRESET, .cpu_clk_en, .cpu, .dma_setup,
		.dma_start, .tr_map, .bank_spr, .bank_pcm, .tr_wr_data, .tr_wr_addr);

	cd_sector_cache #(.clk_hz(clk_hz)) sector_cache_inst (.clk_sys, .nRESET, .dl_active,
		.dl_wr, .dl_addr, .dl_data, .cd_speed, .cache_rd_addr, .cache_dout, .dl_ready);

	cd_dma_engine dma_engine_inst (.clk_sys, .nRESET, .cpu_clk_en, .dma_setup, .dma_start,
		.nbg, .nas, .dtack_n, .sdram_busy, .dma_data_in, .cache_dout, .dma_mem,
		.dma_running, .nbr, .nbgack, .cache_rd_addr);

	cd_transfer_decode transfer_decode_inst (.cpu, .tr_map, .dma_mem, .dma_running,
		.tr_strobe);

endmodule

//--- tb_cd_sys.sv
// Testbench for the CD system controller host side
// Register writes, sector downloads and DMA runs against a simple memory and bus model
`timescale 1ns/1ps

module tb_cd_sys;
	import cd_bus_pkg::*;
	import cd_dma_pkg::*;

	localparam int sig_running = 0;
	localparam int sig_ready = 1;
	localparam int sector_words_n = 1032;	// 8 header words then 1024 data words

	logic clk_sys, nRESET, cpu_clk_en;
	cpu_bus_t cpu;
	logic dl_active, dl_wr;
	logic [10:0] dl_addr;
	logic [15:0] dl_data;
	logic [1:0] cd_speed;
	logic nbg, nas, dtack_n, sdram_busy;
	logic [15:0] dma_data_in;
	logic dl_ready, bank_pcm, dma_running, nbr, nbgack;
	logic [1:0] bank_spr;
	logic [15:0] tr_wr_data;
	logic [19:1] tr_wr_addr;
	tr_strobe_t tr_strobe, seen_strobe, strobe_mask;
	dma_mem_t dma_mem;

	int seed;
	logic [31:0] rnd;
	logic [1:0] grant_cnt;
	logic wr_prev, rd_prev;
	logic [15:0] sector_words [0:sector_words_n-1];
	logic [23:0] wr_addr_q[$];
	logic [15:0] wr_data_q[$];
	logic [23:0] rd_addr_q[$];

	cd_sys #(.clk_hz(75000)) cd_sys_inst (.clk_sys, .nRESET, .cpu_clk_en, .cpu, .dl_active,
		.dl_wr, .dl_addr, .dl_data, .cd_speed, .nbg, .nas, .dtack_n, .sdram_busy, .dma_data_in,
		.dl_ready, .bank_spr, .bank_pcm, .tr_wr_data, .tr_wr_addr, .tr_strobe, .dma_mem,
		.dma_running, .nbr, .nbgack);

	initial
	begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
		cpu_clk_en <= ~cpu_clk_en;	// CPU bus runs at half rate

	// ========================================
	// Memory and bus arbiter model
	// ========================================
	always @(posedge clk_sys)
	begin
		rnd = $random(seed);
		sdram_busy <= nRESET ? rnd[0] : 1'b0;
		if (dma_mem.rd)
			dma_data_in <= dma_mem.addr_in[15:0] ^ 16'hA5A5;
		if (nbr)
		begin
			nbg <= 1'b1;
			grant_cnt <= rnd[3:2];	// Grant 1 to 4 cycles after request
		end
		else if (grant_cnt == 2'd0)
			nbg <= 1'b0;
		else
			grant_cnt <= grant_cnt - 1'b1;
	end

	// Log each memory access on its rising strobe
	always @(posedge clk_sys)
	begin
		wr_prev <= dma_mem.wr;
		rd_prev <= dma_mem.rd;
		if (dma_mem.wr && !wr_prev)
		begin
			wr_addr_q.push_back(dma_mem.addr_out);
			wr_data_q.push_back(dma_mem.data_out);
			assert (!nbgack && dma_running)
			else abort_run($sformatf("Fail at %0t ns: DMA write without bus ownership", $time));
		end
		if (dma_mem.rd && !rd_prev)
			rd_addr_q.push_back(dma_mem.addr_in);
	end

	a_bgack_held: assert property (@(posedge clk_sys) disable iff (!nRESET)
		dma_running |-> !nbgack)
		else abort_run($sformatf("Fail at %0t ns: nbgack high during DMA", $time));

	a_take_bus: assert property (@(posedge clk_sys) disable iff (!nRESET)
		$rose(dma_running) |-> nbr && !nbgack)
		else abort_run($sformatf("Fail at %0t ns: bus taken in wrong order", $time));

	a_request_idle: assert property (@(posedge clk_sys) disable iff (!nRESET)
		!nbr |-> !dma_running)
		else abort_run($sformatf("Fail at %0t ns: DMA running while bus requested", $time));

	a_strobe_mask: assert property (@(posedge clk_sys) disable iff (!nRESET)
		(tr_strobe & ~strobe_mask) == 8'h00)
		else abort_run($sformatf("Fail at %0t ns: unexpected transfer strobe %b", $time,
			tr_strobe));

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "Stopped at first error");
	endtask

	function automatic logic probe(input int sel);
		return (sel == sig_running) ? dma_running : dl_ready;
	endfunction

	task automatic wait_level(input int sel, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		while (probe(sel) !== level && n < limit)
		begin
			@(posedge clk_sys);
			n++;
		end
		if (probe(sel) !== level)
			abort_run($sformatf("Timeout after %0d cycles waiting for %s", limit, what));
	endtask

	// Byte writes pick the lane from address bit 0
	task automatic cpu_write(input logic [23:0] baddr, input logic [15:0] data,
		input logic word);
		@(posedge clk_sys);
		cpu.addr <= baddr[23:1];
		cpu.data <= data;
		cpu.rw <= 1'b0;
		cpu.nas <= 1'b0;
		cpu.nuds <= ~(word | ~baddr[0]);
		cpu.nlds <= ~(word | baddr[0]);
		seen_strobe = '0;
		repeat (6)
		begin
			@(posedge clk_sys);
			seen_strobe = seen_strobe | tr_strobe;
		end
		cpu.nas <= 1'b1;
		cpu.nuds <= 1'b1;
		cpu.nlds <= 1'b1;
		cpu.rw <= 1'b1;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic download_sector();
		int i;
		dl_active <= 1'b1;
		for (i = 0; i < sector_words_n; i++)
		begin
			dl_addr <= i[10:0];
			dl_data <= sector_words[i];
			dl_wr <= 1'b1;
			@(posedge clk_sys);
			dl_wr <= 1'b0;	// Word taken on this falling edge
			repeat (2) @(posedge clk_sys);
		end
		dl_active <= 1'b0;
	endtask

	task automatic run_dma(input logic [15:0] mc, input logic [23:0] a, input logic [23:0] b,
		input logic [15:0] value, input logic [31:0] count);
		cpu_write(24'hFF0064, {8'h00, a[23:16]}, 1'b1);
		cpu_write(24'hFF0066, a[15:0], 1'b1);
		cpu_write(24'hFF0068, {8'h00, b[23:16]}, 1'b1);
		cpu_write(24'hFF006A, b[15:0], 1'b1);
		cpu_write(24'hFF006C, value, 1'b1);
		cpu_write(24'hFF0070, count[31:16], 1'b1);
		cpu_write(24'hFF0072, count[15:0], 1'b1);
		cpu_write(24'hFF007E, mc, 1'b1);
		wr_addr_q.delete();
		wr_data_q.delete();
		rd_addr_q.delete();
		cpu_write(24'hFF0061, 16'h0040, 1'b0);	// Start bit
		wait_level(sig_running, 1'b1, 100, "dma_running to rise");
		wait_level(sig_running, 1'b0, 2000, "dma_running to fall");
	endtask

	task automatic check_count(input string what, input int got, input int expected);
		assert (got == expected)
		else abort_run($sformatf("Fail at %0t ns: %s count %0d, expected %0d", $time, what,
			got, expected));
	endtask

	task automatic check_write(input int k, input logic [23:0] exp_addr,
		input logic [15:0] exp_data);
		assert (wr_addr_q[k] == exp_addr && wr_data_q[k] == exp_data)
		else abort_run($sformatf("Fail at %0t ns: write %0d is %h=%h, expected %h=%h", $time,
			k, wr_addr_q[k], wr_data_q[k], exp_addr, exp_data));
	endtask

	initial
	begin
		int k;
		logic [23:0] src;
		logic [15:0] w;
		seed = 92;
		nRESET = 1'b0;
		cpu_clk_en = 1'b0;
		cpu = '{addr: '0, data: '0, rw: 1'b1, nas: 1'b1, nlds: 1'b1, nuds: 1'b1};
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		cd_speed = 2'd0;
		nbg = 1'b1;
		nas = 1'b1;
		dtack_n = 1'b1;
		sdram_busy = 1'b0;
		dma_data_in = '0;
		grant_cnt = 2'd0;
		wr_prev = 1'b0;
		rd_prev = 1'b0;
		strobe_mask = '0;
		for (k = 0; k < sector_words_n; k++)
		begin
			rnd = $random(seed);
			sector_words[k] = rnd[15:0];
		end

		repeat (2) @(posedge clk_sys);
		nRESET <= 1'b1;
		repeat (3) @(posedge clk_sys);
		assert (nbr && nbgack && !dma_running && !dma_mem.rd && !dma_mem.wr
			&& tr_strobe == 8'h00 && dl_ready)
		else abort_run($sformatf("Fail at %0t ns: outputs not at reset values", $time));

		// Map the fix area, upload once, unmap, upload again
		cpu_write(24'hFF0105, {13'd0, area_fix}, 1'b0);
		cpu_write(24'hFF0129, 16'h0001, 1'b0);
		strobe_mask = '{wr_fix: 1'b1, default: 1'b0};
		cpu_write(24'hE12344, 16'hBEEF, 1'b1);
		assert (seen_strobe == strobe_mask && tr_wr_data == 16'hBEEF
			&& tr_wr_addr == 19'h091A2)
		else abort_run($sformatf("Fail at %0t ns: upload gave strobe %b data %h addr %h",
			$time, seen_strobe, tr_wr_data, tr_wr_addr));
		strobe_mask = '0;
		cpu_write(24'hFF0149, 16'h0001, 1'b0);
		cpu_write(24'hE12344, 16'h1234, 1'b1);
		assert (seen_strobe == 8'h00)
		else abort_run($sformatf("Fail at %0t ns: strobe %b after unmap", $time, seen_strobe));

		// Bank select registers
		cpu_write(24'hFF01A1, 16'h0002, 1'b0);
		cpu_write(24'hFF01A3, 16'h0001, 1'b0);
		assert (bank_spr == 2'd2 && bank_pcm == 1'b1)
		else abort_run($sformatf("Fail at %0t ns: banks spr %0d pcm %0d, expected 2 and 1",
			$time, bank_spr, bank_pcm));

		// ========================================
		// DMA modes
		// ========================================
		run_dma(mc_fill_a, 24'h0A1230, 24'h000000, 16'h5AC3, 32'd5);
		check_count("fill write", wr_addr_q.size(), 5);
		check_count("fill read", rd_addr_q.size(), 0);
		for (k = 0; k < 5; k++)
			check_write(k, 24'h0A1230 + 24'(2 * k), 16'h5AC3);

		run_dma(mc_copy_a, 24'h013570, 24'h2468A0, 16'h0000, 32'd6);
		check_count("copy write", wr_addr_q.size(), 6);
		check_count("copy read", rd_addr_q.size(), 6);
		for (k = 0; k < 6; k++)
		begin
			src = 24'h013570 + 24'(2 * k);
			assert (rd_addr_q[k] == src)
			else abort_run($sformatf("Fail at %0t ns: read %0d from %h, expected %h", $time,
				k, rd_addr_q[k], src));
			check_write(k, 24'h2468A0 + 24'(2 * k), src[15:0] ^ 16'hA5A5);
		end

		fork
			download_sector();
			wait_level(sig_ready, 1'b0, 5000, "dl_ready to fall");
		join
		wait_level(sig_ready, 1'b1, 2000, "dl_ready to rise after the bank swap");

		run_dma(mc_cd_a, 24'h0C0100, 24'h000000, 16'h0000, 32'd6);
		check_count("cache copy write", wr_addr_q.size(), 6);
		check_count("cache copy read", rd_addr_q.size(), 0);
		for (k = 0; k < 6; k++)
		begin
			w = sector_words[8 + k];
			check_write(k, 24'h0C0100 + 24'(2 * k), {w[7:0], w[15:8]});	// Bytes swapped
		end

		$display("** PASS **");
		$finish;
	end

endmodule

//--- list.f
cd_bus_pkg.sv
cd_dma_pkg.sv
cd_host_regs.sv
cd_sector_cache.sv
cd_dma_engine.sv
cd_transfer_decode.sv
cd_sys.sv
tb_cd_sys.sv

//--- Makefile
# Verilator build and run for the CD system controller testbench
VERILATOR ?= verilator
TOP ?= tb_cd_sys
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
